/* logic/memcard.sv */
`timescale 1ns/1ps

module memcard
	import memcard_csr_pkg::*, memcard_bus_pkg::*;
(
	input  logic                 sys_clk,
	input  logic                 sys_rst,

	input  csr_addr_t            csr_a,
	input  logic                 csr_we,
	input  csr_data_t            csr_di,
	output csr_data_t            csr_do,

	input  logic [cmd_lanes-1:0] mc_cmd_sense,
	output logic [cmd_lanes-1:0] mc_cmd_level,
	output logic                 mc_cmd_drive,
	input  logic [dat_lanes-1:0] mc_d_sense,
	output logic [dat_lanes-1:0] mc_d_level,
	output logic                 mc_d_drive,
	output logic                 mc_clk
);

	clkdiv_t     clkdiv;
	lane_mode_t  cmd_mode;
	lane_mode_t  dat_mode;
	lane_cmd_t   cmd_ctl;
	lane_cmd_t   dat_ctl;
	lane_state_t cmd_state;
	lane_state_t dat_state;
	cmd_word_t   cmd_load_word;
	dat_word_t   dat_load_word;
	cmd_word_t   cmd_word;
	dat_word_t   dat_word;
	logic        bit_strobe;

	memcard_regs regs (
		.sys_clk       (sys_clk),
		.sys_rst       (sys_rst),
		.csr_a         (csr_a),
		.csr_we        (csr_we),
		.csr_di        (csr_di),
		.csr_do        (csr_do),
		.cmd_state     (cmd_state),
		.dat_state     (dat_state),
		.cmd_word      (cmd_word),
		.dat_word      (dat_word),
		.clkdiv        (clkdiv),
		.cmd_mode      (cmd_mode),
		.dat_mode      (dat_mode),
		.cmd_ctl       (cmd_ctl),
		.dat_ctl       (dat_ctl),
		.cmd_load_word (cmd_load_word),
		.dat_load_word (dat_load_word)
	);

	memcard_clkgen clkgen (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.clkdiv     (clkdiv),
		.cmd_mode   (cmd_mode),
		.dat_mode   (dat_mode),
		.cmd_state  (cmd_state),
		.dat_state  (dat_state),
		.mc_clk     (mc_clk),
		.bit_strobe (bit_strobe)
	);

	memcard_lane #(
		.lanes (cmd_lanes),
		.beats (cmd_beats)
	) cmd_lane (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.bit_strobe (bit_strobe),
		.mode       (cmd_mode),
		.ctl        (cmd_ctl),
		.load_word  (cmd_load_word),
		.sense      (mc_cmd_sense),
		.state      (cmd_state),
		.word       (cmd_word),
		.level      (mc_cmd_level),
		.drive      (mc_cmd_drive)
	);

	memcard_lane #(
		.lanes (dat_lanes),
		.beats (dat_beats)
	) dat_lane (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.bit_strobe (bit_strobe),
		.mode       (dat_mode),
		.ctl        (dat_ctl),
		.load_word  (dat_load_word),
		.sense      (mc_d_sense),
		.state      (dat_state),
		.word       (dat_word),
		.level      (mc_d_level),
		.drive      (mc_d_drive)
	);

endmodule

/* logic/memcard_bus_pkg.sv */
package memcard_bus_pkg;

	localparam int cmd_lanes = 1; // one-bit command line.
	localparam int cmd_beats = 8; // one byte per transfer.
	localparam int dat_lanes = 4; // four-bit data bus.
	localparam int dat_beats = 8; // one word per transfer.

	typedef logic [cmd_lanes*cmd_beats-1:0] cmd_word_t;
	typedef logic [dat_lanes*dat_beats-1:0] dat_word_t;

	// lane direction, set by software.
	typedef struct packed {
		logic tx_enabled;
		logic rx_enabled;
	} lane_mode_t;

	// one-cycle strobes from the register bank.
	typedef struct packed {
		logic load;          // new transmit word written.
		logic clear_pending; // drop rx_pending and restart the beat count.
		logic clear_started; // drop rx_started.
	} lane_cmd_t;

	// lane status, read back by software and used for clock gating.
	typedef struct packed {
		logic tx_pending;
		logic rx_pending;
		logic rx_started;
	} lane_state_t;

endpackage

/* logic/memcard_clkgen.sv */
`timescale 1ns/1ps

module memcard_clkgen
	import memcard_csr_pkg::*, memcard_bus_pkg::*;
(
	input  logic        sys_clk,
	input  logic        sys_rst,

	input  clkdiv_t     clkdiv,
	input  lane_mode_t  cmd_mode,
	input  lane_mode_t  dat_mode,
	input  lane_state_t cmd_state,
	input  lane_state_t dat_state,

	output logic        mc_clk,
	output logic        bit_strobe
);

	clkdiv_t div_cnt;
	logic    div_ce;
	logic    clk_active;

	assign div_ce = (div_cnt == '0); // once every clkdiv+1 cycles.

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			div_cnt <= '0;
		else if (div_ce)
			div_cnt <= clkdiv;
		else
			div_cnt <= div_cnt - 1'b1;
	end

	// run while tx lanes have data to send and rx lanes have room.
	assign clk_active = (~cmd_mode.tx_enabled | cmd_state.tx_pending)
		& (~cmd_mode.rx_enabled | ~cmd_state.rx_pending)
		& (~dat_mode.tx_enabled | dat_state.tx_pending)
		& (~dat_mode.rx_enabled | ~dat_state.rx_pending);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			mc_clk <= 1'b0;
			bit_strobe <= 1'b0;
		end else begin
			if (div_ce & clk_active)
				mc_clk <= ~mc_clk;
			bit_strobe <= div_ce & clk_active & ~mc_clk; // high while mc_clk is newly high.
		end
	end

endmodule

/* logic/memcard_csr_pkg.sv */
package memcard_csr_pkg;

	localparam int csr_addr_width = 14;
	localparam int csr_data_width = 32;
	localparam int clkdiv_width = 11;

	typedef logic [csr_addr_width-1:0] csr_addr_t; // full csr address.
	typedef logic [csr_data_width-1:0] csr_data_t; // csr data word.
	typedef logic [clkdiv_width-1:0] clkdiv_t; // half period count, in sys_clk cycles minus one.

	// compared with csr_a[13:10].
	localparam logic [3:0] csr_bank = 4'd0;

	localparam clkdiv_t clkdiv_reset = 11'd10; // divider value after reset.

	// register index, taken from csr_a[2:0].
	typedef enum logic [2:0] {
		reg_clkdiv   = 3'd0, // clock divider.
		reg_enable   = 3'd1, // {dat_rx, dat_tx, cmd_rx, cmd_tx} enables.
		reg_pending  = 3'd2, // {dat_rx, dat_tx, cmd_rx, cmd_tx} pending, write 1 to clear rx.
		reg_started  = 3'd3, // {dat_rx, cmd_rx} started, write 1 to clear.
		reg_cmd_data = 3'd4, // command shift byte.
		reg_dat_data = 3'd5  // data shift word.
	} csr_reg_e;

endpackage

/* logic/memcard_lane.sv */
`timescale 1ns/1ps

module memcard_lane
	import memcard_bus_pkg::*;
#(
	parameter int lanes = 1,
	parameter int beats = 8
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst,

	input  logic                   bit_strobe,
	input  lane_mode_t             mode,
	input  lane_cmd_t              ctl,
	input  logic [lanes*beats-1:0] load_word,
	input  logic [lanes-1:0]       sense,

	output lane_state_t            state,
	output logic [lanes*beats-1:0] word,
	output logic [lanes-1:0]       level,
	output logic                   drive
);

	localparam int width = lanes * beats;
	localparam int count_w = (beats > 1) ? $clog2(beats) : 1;
	localparam logic [count_w-1:0] last_beat = count_w'(beats - 1);

	logic [count_w-1:0] beat_cnt;
	logic               start_seen;
	logic               beat_en;

	assign start_seen = (sense == '0); // all lines low marks the start beat.

	// tx shifts every strobe, rx only once the start level was seen.
	assign beat_en = bit_strobe & (mode.tx_enabled
		| (mode.rx_enabled & (state.rx_started | start_seen)));

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= '0;
			beat_cnt <= '0;
		end else begin
			if (ctl.load) begin
				state.tx_pending <= 1'b1;
				beat_cnt <= '0;
			end
			if (ctl.clear_pending) begin
				state.rx_pending <= 1'b0;
				beat_cnt <= '0;
			end
			if (ctl.clear_started)
				state.rx_started <= 1'b0;

			// a strobe overrides a write in the same cycle.
			if (beat_en) begin
				if (mode.rx_enabled)
					state.rx_started <= 1'b1;
				if (beat_cnt == last_beat) begin
					beat_cnt <= '0;
					if (mode.tx_enabled)
						state.tx_pending <= 1'b0;
					if (mode.rx_enabled)
						state.rx_pending <= 1'b1;
				end else begin
					beat_cnt <= beat_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (beat_en)
			word <= {word[width-lanes-1:0], sense}; // oldest sample ends in the top beat.
		else if (ctl.load)
			word <= load_word;
	end

	assign level = word[width-1 -: lanes]; // top beat goes out first.
	assign drive = mode.tx_enabled;

endmodule

/* logic/memcard_regs.sv */
`timescale 1ns/1ps

module memcard_regs
	import memcard_csr_pkg::*, memcard_bus_pkg::*;
(
	input  logic        sys_clk,
	input  logic        sys_rst,

	input  csr_addr_t   csr_a,
	input  logic        csr_we,
	input  csr_data_t   csr_di,
	output csr_data_t   csr_do,

	input  lane_state_t cmd_state,
	input  lane_state_t dat_state,
	input  cmd_word_t   cmd_word,
	input  dat_word_t   dat_word,

	output clkdiv_t     clkdiv,
	output lane_mode_t  cmd_mode,
	output lane_mode_t  dat_mode,
	output lane_cmd_t   cmd_ctl,
	output lane_cmd_t   dat_ctl,
	output cmd_word_t   cmd_load_word,
	output dat_word_t   dat_load_word
);

	logic     bank_sel;
	logic     wr;
	csr_reg_e reg_idx;

	assign bank_sel = (csr_a[13:10] == csr_bank);
	assign wr = bank_sel & csr_we;
	assign reg_idx = csr_reg_e'(csr_a[2:0]);

	// the written word goes straight to the lanes, load qualifies it.
	assign cmd_load_word = csr_di[$bits(cmd_word_t)-1:0];
	assign dat_load_word = csr_di;

	always_comb begin
		cmd_ctl.load = wr & (reg_idx == reg_cmd_data);
		cmd_ctl.clear_pending = wr & (reg_idx == reg_pending) & csr_di[1];
		cmd_ctl.clear_started = wr & (reg_idx == reg_started) & csr_di[0];

		dat_ctl.load = wr & (reg_idx == reg_dat_data);
		dat_ctl.clear_pending = wr & (reg_idx == reg_pending) & csr_di[3];
		dat_ctl.clear_started = wr & (reg_idx == reg_started) & csr_di[1];
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
			clkdiv <= clkdiv_reset;
			cmd_mode <= '0;
			dat_mode <= '0;
		end else begin
			csr_do <= '0; // unselected bank reads as zero.
			if (bank_sel) begin
				case (reg_idx)
					reg_clkdiv: csr_do <= csr_data_t'(clkdiv);
					reg_enable: begin
						csr_do <= csr_data_t'({dat_mode.rx_enabled, dat_mode.tx_enabled,
							cmd_mode.rx_enabled, cmd_mode.tx_enabled});
					end
					reg_pending: begin
						csr_do <= csr_data_t'({dat_state.rx_pending, dat_state.tx_pending,
							cmd_state.rx_pending, cmd_state.tx_pending});
					end
					reg_started: begin
						csr_do <= csr_data_t'({dat_state.rx_started, cmd_state.rx_started});
					end
					reg_cmd_data: csr_do <= csr_data_t'(cmd_word);
					reg_dat_data: csr_do <= csr_data_t'(dat_word);
					default: csr_do <= '0;
				endcase
			end

			if (wr) begin
				case (reg_idx)
					reg_clkdiv: clkdiv <= csr_di[$bits(clkdiv_t)-1:0];
					reg_enable: begin
						{dat_mode.rx_enabled, dat_mode.tx_enabled,
							cmd_mode.rx_enabled, cmd_mode.tx_enabled} <= csr_di[3:0];
					end
					default: ; // other registers only produce strobes.
				endcase
			end
		end
	end

endmodule

/* memcard.f */
logic/memcard_csr_pkg.sv
logic/memcard_bus_pkg.sv
logic/memcard_regs.sv
logic/memcard_clkgen.sv
logic/memcard_lane.sv
logic/memcard.sv
verification/memcard_assertions.sv
verification/memcard_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f memcard.f --top-module memcard_tb -o memcard_sim

./obj_dir/memcard_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
	exit 1
fi
grep -q "Verification passed" sim.log

/* verification/memcard_assertions.sv */
`timescale 1ns/1ps

module memcard_assertions
	import memcard_bus_pkg::*;
(
	input logic        sys_clk,
	input logic        sys_rst,
	input logic        mc_clk,
	input logic        bit_strobe,
	input lane_mode_t  cmd_mode,
	input lane_mode_t  dat_mode,
	input lane_state_t cmd_state,
	input lane_state_t dat_state
);

	logic rx_wait;

	assign rx_wait = (cmd_mode.rx_enabled & cmd_state.rx_pending)
		| (dat_mode.rx_enabled & dat_state.rx_pending); // a received word waits for software.

	strobe_after_rise: assert property (@(posedge sys_clk) disable iff (sys_rst)
		bit_strobe |-> (mc_clk && !$past(mc_clk)))
		else $error("bit_strobe without a rising card clock");

	clock_held: assert property (@(posedge sys_clk) disable iff (sys_rst)
		rx_wait |=> $stable(mc_clk))
		else $error("card clock moved while a received word waits");

	drive_reset: assert property (@(posedge sys_clk)
		$past(sys_rst) |-> (!cmd_mode.tx_enabled && !dat_mode.tx_enabled))
		else $error("drive enable set after reset");

endmodule

bind memcard_clkgen memcard_assertions clkgen_checks (.*);

/* verification/memcard_tb.sv */
`timescale 1ns/1ps

module memcard_tb
	import memcard_csr_pkg::*;
;
	logic        sys_clk = 1'b0;
	logic        sys_rst;
	csr_addr_t   csr_a;
	logic        csr_we;
	csr_data_t   csr_di;
	csr_data_t   csr_do;
	logic        mc_cmd_sense;
	logic        mc_cmd_level;
	logic        mc_cmd_drive;
	logic [3:0]  mc_d_sense;
	logic [3:0]  mc_d_level;
	logic        mc_d_drive;
	logic        mc_clk;
	logic [31:0] rng = 32'hf2a;
	int          cycles = 0;

	memcard dut_i (.*);

	always #20 sys_clk = ~sys_clk;

	function automatic logic [31:0] xorshift(input logic [31:0] seed);
		logic [31:0] x;
		x = seed;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	always @(posedge sys_clk) begin
		cycles++;
		if (cycles >= 20000)
			fail_now("timeout: the tests did not finish within 20000 cycles");
	end

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
			else fail_now($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
	endtask

	task automatic tick(input int n);
		repeat (n) @(posedge sys_clk);
		#2;
	endtask

	task automatic csr_write(input csr_reg_e r, input logic [31:0] d);
		csr_a = csr_addr_t'(r);
		csr_di = d;
		csr_we = 1'b1;
		tick(1); // write lands on this edge.
		csr_we = 1'b0;
	endtask

	task automatic csr_get(input csr_reg_e r, output logic [31:0] d);
		csr_a = csr_addr_t'(r);
		tick(1);
		d = csr_do;
	endtask

	task automatic csr_read(input csr_reg_e r, input logic [31:0] exp, input string name);
		logic [31:0] d;
		csr_get(r, d);
		check_eq(name, d, exp);
	endtask

	// returns the cycles spent until mc_clk is seen rising.
	task automatic wait_rise(output int n);
		logic prev;
		n = 0;
		do begin
			prev = mc_clk;
			tick(1);
			n++;
		end while (!(mc_clk && !prev));
	endtask

	task automatic wait_fall();
		logic prev;
		do begin
			prev = mc_clk;
			tick(1);
		end while (!(!mc_clk && prev));
	endtask

	task automatic check_still(input int n);
		logic held;
		held = mc_clk;
		repeat (n) begin
			tick(1);
			assert (mc_clk === held) else fail_now("card clock moved while it should be stopped");
		end
	endtask

	task automatic test_regs();
		check_eq("mc_clk", mc_clk, 0);
		check_eq("mc_cmd_drive", mc_cmd_drive, 0);
		check_eq("mc_d_drive", mc_d_drive, 0);
		csr_read(reg_clkdiv, 10, "clkdiv");
		csr_read(reg_enable, 0, "enable");
		csr_read(reg_pending, 0, "pending");
		csr_read(reg_started, 0, "started");
		csr_write(reg_clkdiv, 5);
		csr_read(reg_clkdiv, 5, "clkdiv");
		csr_write(reg_enable, 4'b1010);
		csr_read(reg_enable, 4'b1010, "enable");
		csr_write(reg_enable, 0);
		csr_write(reg_clkdiv, 10);
	endtask

	task automatic test_cmd_tx();
		logic [7:0] b;
		logic [7:0] got;
		int n;
		rng = xorshift(rng);
		b = rng[7:0];
		csr_write(reg_enable, 4'b0001);
		csr_write(reg_cmd_data, b);
		for (int i = 7; i >= 0; i--) begin
			wait_rise(n);
			check_eq("mc_cmd_drive", mc_cmd_drive, 1);
			got[i] = mc_cmd_level;
		end
		check_eq("mc_cmd_level", got, b);
		tick(3);
		csr_read(reg_pending, 0, "pending");
		check_still(4 * 22);
	endtask

	task automatic test_cmd_rx();
		logic [7:0] exp;
		int n;
		rng = xorshift(rng);
		exp = {1'b0, rng[6:0]}; // start bit is the oldest sample.
		csr_write(reg_enable, 4'b0010);
		repeat (3) wait_rise(n);
		for (int i = 7; i >= 0; i--) begin
			wait_fall();
			mc_cmd_sense = exp[i];
		end
		wait_rise(n);
		tick(3);
		csr_read(reg_pending, 4'b0010, "pending");
		csr_read(reg_started, 2'b01, "started");
		csr_read(reg_cmd_data, exp, "cmd_data");
		check_still(4 * 22);
		mc_cmd_sense = 1'b1;
		csr_write(reg_pending, 4'b0010);
		csr_write(reg_started, 2'b01);
		wait_rise(n);
		csr_write(reg_enable, 0);
	endtask

	task automatic test_dat_tx();
		logic [31:0] w;
		logic [31:0] got;
		int n;
		rng = xorshift(rng);
		w = rng;
		csr_write(reg_enable, 4'b0100);
		csr_write(reg_dat_data, w);
		for (int i = 7; i >= 0; i--) begin
			wait_rise(n);
			check_eq("mc_d_drive", mc_d_drive, 1);
			got[i*4 +: 4] = mc_d_level;
		end
		check_eq("mc_d_level", got, w);
		tick(3);
		csr_read(reg_pending, 0, "pending");
	endtask

	task automatic test_dat_rx();
		logic [31:0] exp;
		int n;
		rng = xorshift(rng);
		exp = {4'h0, rng[27:0]};
		csr_write(reg_enable, 4'b1000);
		repeat (3) wait_rise(n);
		for (int i = 7; i >= 0; i--) begin
			wait_fall();
			mc_d_sense = exp[i*4 +: 4];
		end
		wait_rise(n);
		tick(3);
		csr_read(reg_pending, 4'b1000, "pending");
		csr_read(reg_dat_data, exp, "dat_data");
		mc_d_sense = 4'hf;
		csr_write(reg_pending, 4'b1000);
		csr_write(reg_started, 2'b10);
		csr_write(reg_enable, 0);
	endtask

	task automatic test_divider();
		int n;
		logic [31:0] d;
		for (int k = 0; k < 2; k++) begin
			int div;
			div = (k == 0) ? 3 : 0;
			csr_write(reg_clkdiv, div);
			csr_write(reg_enable, 4'b0001);
			rng = xorshift(rng);
			csr_write(reg_cmd_data, rng[7:0]);
			wait_rise(n);
			wait_rise(n);
			check_eq("mc_clk period", n, 2 * (div + 1));
			do
				csr_get(reg_pending, d);
			while (d[0]);
		end
	endtask

	initial begin
		sys_rst = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		mc_cmd_sense = 1'b1;
		mc_d_sense = 4'hf;
		repeat (2) @(posedge sys_clk);
		#2;
		sys_rst = 1'b0;
		test_regs();
		test_cmd_tx();
		test_cmd_rx();
		test_dat_tx();
		test_dat_rx();
		test_divider();
		$display("Verification passed");
		$finish;
	end

endmodule
